//--- ex_stage.f
src/ex_pkg.sv
src/ex_ctrl_if.sv
src/op_decode.sv
src/alu_execute.sv
src/branch_unit.sv
src/lsu_request.sv
src/result_writeback.sv
src/ex_stage_top.sv
dv/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  # Package and interface first, top level last
  - src/ex_pkg.sv
  - src/ex_ctrl_if.sv
  - src/op_decode.sv
  - src/alu_execute.sv
  - src/branch_unit.sv
  - src/lsu_request.sv
  - src/result_writeback.sv
  - src/ex_stage_top.sv

  # Directed testbench, top module tb_ex_stage
  - target: test
    files:
      - dv/tb_ex_stage.sv

//--- dv/tb_ex_stage.sv
/*
 * Directed testbench of the execute stage with clock and reset, operand
 * generator, reference model of the operand rules and one task per test
 */
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int ALU_ROUNDS   = 8;
    // Cycles spent by all tests together
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 + 11 * ALU_ROUNDS + 6 * 4 + 2 * 4
                                + 6 + 5 + 7 + 6;
    localparam int MAX_CYCLES   = 2 * TEST_CYCLES + 20;

    logic                     clk;
    logic                     reset;
    logic                     stall_i;
    op_e                      op_i;
    logic [XLEN-1:0]          pc_i;
    logic [XLEN-1:0]          rs1_i;
    logic [XLEN-1:0]          rs2_i;
    logic [XLEN-1:0]          imm_i;
    logic [DEFAULT_TAG_W-1:0] tag_i;
    logic                     killed_o;
    logic                     jump_o;
    logic [XLEN-1:0]          jump_target_o;
    logic                     write_enable_o;
    op_e                      op_o;
    logic [XLEN-1:0]          result_o;
    logic [XLEN-1:0]          mem_address_o;
    logic                     mem_read_enable_o;
    logic [3:0]               mem_write_enable_o;
    logic [XLEN-1:0]          mem_write_data_o;

    int                       errors = 0;
    int                       cycle_count = 0;
    logic [31:0]              lcg_state = 32'ha66c11f9;
    // Tag the stage should hold after the taken jumps issued so far
    logic [DEFAULT_TAG_W-1:0] exp_tag = '0;

    ex_stage_top uut (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall_i),
        .op_i               (op_i),
        .pc_i               (pc_i),
        .rs1_i              (rs1_i),
        .rs2_i              (rs2_i),
        .imm_i              (imm_i),
        .tag_i              (tag_i),
        .killed_o           (killed_o),
        .jump_o             (jump_o),
        .jump_target_o      (jump_target_o),
        .write_enable_o     (write_enable_o),
        .op_o               (op_o),
        .result_o           (result_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: run went past %0d cycles with %0d errors", MAX_CYCLES, errors);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Register result from the operand rules
    function automatic logic [31:0] alu_model(op_e op, logic [31:0] pc, logic [31:0] rs1,
                                              logic [31:0] rs2, logic [31:0] imm);
        logic [31:0] fill;
        fill = rs1[31] ? ~(32'hffff_ffff >> rs2[4:0]) : 32'h0;
        case (op)
            SUB:       return rs1 - rs2;
            AND:       return rs1 & rs2;
            OR:        return rs1 | rs2;
            XOR:       return rs1 ^ rs2;
            SLL:       return rs1 << rs2[4:0];
            SRL:       return rs1 >> rs2[4:0];
            SRA:       return (rs1 >> rs2[4:0]) | fill;
            SLT:       return {31'b0, (rs1[31] != rs2[31]) ? rs1[31] : (rs1 < rs2)};
            SLTU:      return {31'b0, rs1 < rs2};
            LUI:       return imm;
            JAL, JALR: return pc + 32'd4;
            default:   return rs1 + rs2;
        endcase
    endfunction

    function automatic logic branch_model(op_e op, logic [31:0] rs1, logic [31:0] rs2);
        logic slt;
        slt = (rs1[31] != rs2[31]) ? rs1[31] : (rs1 < rs2);
        case (op)
            BEQ:     return rs1 == rs2;
            BNE:     return rs1 != rs2;
            BLT:     return slt;
            BLTU:    return rs1 < rs2;
            BGE:     return !slt;
            default: return !(rs1 < rs2);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    // Drive at the falling edge, then let the combinational outputs settle
    task automatic present_op(input op_e op, input logic [31:0] pc, input logic [31:0] rs1,
                              input logic [31:0] rs2, input logic [31:0] imm,
                              input logic [DEFAULT_TAG_W-1:0] tag);
        op_i  = op;
        pc_i  = pc;
        rs1_i = rs1;
        rs2_i = rs2;
        imm_i = imm;
        tag_i = tag;
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic after_reset_checks();
        check_value("write_enable_o", 0, write_enable_o);
        present_op(NOP, 0, 0, 0, 0, '0);
        check_value("killed_o", 0, killed_o);
        check_value("jump_o", 0, jump_o);
        @(negedge clk);
        check_value("write_enable_o", 0, write_enable_o);
    endtask

    task automatic alu_ops();
        op_e         alu_list [11] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI};
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        foreach (alu_list[i]) begin
            for (int r = 0; r < ALU_ROUNDS; r++) begin
                pc  = next_rand() & ~32'h3;
                rs1 = next_rand();
                // Odd rounds compare close values
                rs2 = r[0] ? rs1 ^ (next_rand() & 32'hf) : next_rand();
                imm = next_rand();
                present_op(alu_list[i], pc, rs1, rs2, imm, exp_tag);
                @(negedge clk);
                check_value("result_o", alu_model(alu_list[i], pc, rs1, rs2, imm), result_o);
                check_value("write_enable_o", 1, write_enable_o);
                check_value("op_o", 32'(alu_list[i]), 32'(op_o));
            end
        end
    endtask

    task automatic branch_conditions();
        op_e         br_list [6] = '{BEQ, BNE, BLT, BLTU, BGE, BGEU};
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic        taken;
        foreach (br_list[i]) begin
            // Equal, negative below positive, positive above negative, small below big
            for (int k = 0; k < 4; k++) begin
                pc  = next_rand() & ~32'h3;
                imm = next_rand() & 32'h0000_1ffe;
                rs1 = next_rand();
                rs2 = next_rand();
                case (k)
                    0: rs2 = rs1;
                    1: begin
                        rs1 = rs1 | 32'h8000_0000;
                        rs2 = rs2 & 32'h7fff_ffff;
                    end
                    2: begin
                        rs1 = rs1 & 32'h7fff_ffff;
                        rs2 = rs2 | 32'h8000_0000;
                    end
                    default: begin
                        rs1 = rs1 & 32'h00ff_ffff;
                        rs2 = rs1 + 32'd1;
                    end
                endcase
                taken = branch_model(br_list[i], rs1, rs2);
                present_op(br_list[i], pc, rs1, rs2, imm, exp_tag);
                check_value("jump_o", taken, jump_o);
                check_value("jump_target_o", pc + imm, jump_target_o);
                check_value("killed_o", 0, killed_o);
                if (taken) begin
                    exp_tag++;
                end
                @(negedge clk);
                check_value("write_enable_o", 0, write_enable_o);
            end
        end
    endtask

    task automatic jump_links();
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] imm;
        for (int k = 0; k < 8; k++) begin
            pc  = next_rand() & ~32'h3;
            rs1 = next_rand();
            imm = next_rand() & 32'h000f_ffff;
            present_op(k[0] ? JALR : JAL, pc, rs1, 0, imm, exp_tag);
            check_value("jump_o", 1, jump_o);
            check_value("jump_target_o", k[0] ? (rs1 + imm) & ~32'h1 : pc + imm, jump_target_o);
            exp_tag++;
            @(negedge clk);
            check_value("result_o", pc + 32'd4, result_o);
            check_value("write_enable_o", 1, write_enable_o);
        end
    endtask

    task automatic stale_tag_kill();
        logic [DEFAULT_TAG_W-1:0] old_tag;
        logic [31:0]              rs1;
        logic [31:0]              rs2;
        old_tag = exp_tag;
        present_op(JAL, 32'h100, 0, 0, 32'h40, exp_tag);
        check_value("jump_o", 1, jump_o);
        exp_tag++;
        @(negedge clk);
        // ALU op, load, store and jump of the old flow are all dropped
        present_op(ADD, 32'h104, 32'h11, 32'h22, 0, old_tag);
        check_value("killed_o", 1, killed_o);
        check_value("jump_o", 0, jump_o);
        @(negedge clk);
        check_value("write_enable_o", 0, write_enable_o);
        present_op(LW, 32'h108, 32'h2000, 0, 32'h8, old_tag);
        check_value("mem_read_enable_o", 0, mem_read_enable_o);
        @(negedge clk);
        check_value("write_enable_o", 0, write_enable_o);
        present_op(SW, 32'h10c, 32'h2000, 32'h55, 32'h4, old_tag);
        check_value("mem_write_enable_o", 0, mem_write_enable_o);
        @(negedge clk);
        present_op(JAL, 32'h110, 0, 0, 32'h80, old_tag);
        check_value("jump_o", 0, jump_o);
        check_value("killed_o", 1, killed_o);
        @(negedge clk);
        check_value("write_enable_o", 0, write_enable_o);
        // Killed jump leaves the tag alone, so the new flow still runs
        rs1 = next_rand();
        rs2 = next_rand();
        present_op(ADD, 32'h140, rs1, rs2, 0, exp_tag);
        check_value("killed_o", 0, killed_o);
        @(negedge clk);
        check_value("write_enable_o", 1, write_enable_o);
        check_value("result_o", rs1 + rs2, result_o);
    endtask

    task automatic memory_requests();
        op_e         load_list [5] = '{LB, LBU, LH, LHU, LW};
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        foreach (load_list[i]) begin
            rs1 = next_rand();
            imm = next_rand() & 32'h0000_0fff;
            present_op(load_list[i], 0, rs1, 0, imm, exp_tag);
            check_value("mem_read_enable_o", 1, mem_read_enable_o);
            check_value("mem_address_o", (rs1 + imm) & ~32'h3, mem_address_o);
            check_value("mem_write_enable_o", 0, mem_write_enable_o);
            @(negedge clk);
            check_value("write_enable_o", 1, write_enable_o);
        end
        // Four byte lanes, two halves, one word
        for (int s = 0; s < 7; s++) begin
            rs1 = next_rand() & ~32'h3;
            rs2 = next_rand();
            imm = (next_rand() & 32'h0000_0ff0) | (s < 4 ? s : (s == 4 ? 0 : 2));
            present_op(s < 4 ? SB : (s < 6 ? SH : SW), 0, rs1, rs2, imm, exp_tag);
            check_value("mem_address_o", (rs1 + imm) & ~32'h3, mem_address_o);
            check_value("mem_read_enable_o", 0, mem_read_enable_o);
            if (s < 4) begin
                check_value("mem_write_enable_o", 4'b0001 << s, mem_write_enable_o);
                check_value("mem_write_data_o", {4{rs2[7:0]}}, mem_write_data_o);
            end else if (s < 6) begin
                check_value("mem_write_enable_o", s == 4 ? 4'b0011 : 4'b1100,
                            mem_write_enable_o);
                check_value("mem_write_data_o", {2{rs2[15:0]}}, mem_write_data_o);
            end else begin
                check_value("mem_write_enable_o", 4'b1111, mem_write_enable_o);
                check_value("mem_write_data_o", rs2, mem_write_data_o);
            end
            @(negedge clk);
            check_value("write_enable_o", 0, write_enable_o);
        end
    endtask

    task automatic stall_hold();
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] b1;
        logic [31:0] b2;
        a1 = next_rand();
        a2 = next_rand();
        b1 = next_rand();
        b2 = next_rand();
        present_op(ADD, 0, a1, a2, 0, exp_tag);
        @(negedge clk);
        check_value("result_o", a1 + a2, result_o);
        stall_i = 1'b1;
        present_op(SUB, 0, b1, b2, 0, exp_tag);
        repeat (3) begin
            @(negedge clk);
            check_value("result_o", a1 + a2, result_o);
            check_value("op_o", 32'(ADD), 32'(op_o));
            check_value("write_enable_o", 1, write_enable_o);
        end
        stall_i = 1'b0;
        @(negedge clk);
        check_value("result_o", b1 - b2, result_o);
        check_value("op_o", 32'(SUB), 32'(op_o));
        check_value("write_enable_o", 1, write_enable_o);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset   = 1'b1;
        stall_i = 1'b0;
        // Register-writing op held during reset
        op_i    = ADD;
        pc_i    = '0;
        rs1_i   = '0;
        rs2_i   = '0;
        imm_i   = '0;
        tag_i   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        after_reset_checks();
        alu_ops();
        branch_conditions();
        jump_links();
        stale_tag_kill();
        memory_requests();
        stall_hold();

        $display("Run finished after %0d cycles with %0d errors", cycle_count, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/ex_stage_top.sv
/*
 * Integer execute stage: decoder, ALU, branch unit, memory
 * request and write-back joined behind plain ports
 */
`timescale 1ns/1ps

module ex_stage_top #(
    parameter int TagWidth = ex_pkg::DEFAULT_TAG_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  ex_pkg::op_e             op_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] rs1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  logic [TagWidth-1:0]     tag_i,
    output logic                    killed_o,
    output logic                    jump_o,
    output logic [ex_pkg::XLEN-1:0] jump_target_o,
    output logic                    write_enable_o,
    output ex_pkg::op_e             op_o,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic [ex_pkg::XLEN-1:0] mem_address_o,
    output logic                    mem_read_enable_o,
    output logic [3:0]              mem_write_enable_o,
    output logic [ex_pkg::XLEN-1:0] mem_write_data_o
);
    import ex_pkg::*;

    // ALU results toward write-back, branch and memory units
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] and_res;
    logic [XLEN-1:0] or_res;
    logic [XLEN-1:0] xor_res;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic            lt;
    logic            ltu;
    logic            eq;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] addr_sum;

    ex_ctrl_if ctrl_bus ();

    op_decode u_decode (
        .op_i (op_i),
        .ctrl (ctrl_bus.decoder)
    );

    alu_execute u_alu (
        .pc_i       (pc_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .imm_i      (imm_i),
        .sum_o      (sum),
        .diff_o     (diff),
        .and_o      (and_res),
        .or_o       (or_res),
        .xor_o      (xor_res),
        .sll_o      (sll_res),
        .srl_o      (srl_res),
        .sra_o      (sra_res),
        .lt_o       (lt),
        .ltu_o      (ltu),
        .eq_o       (eq),
        .link_o     (link),
        .addr_sum_o (addr_sum)
    );

    branch_unit #(
        .TagWidth (TagWidth)
    ) u_branch (
        .clk           (clk),
        .reset         (reset),
        .tag_i         (tag_i),
        .ctrl          (ctrl_bus.consumer),
        .eq_i          (eq),
        .lt_i          (lt),
        .ltu_i         (ltu),
        .pc_i          (pc_i),
        .imm_i         (imm_i),
        .addr_sum_i    (addr_sum),
        .killed_o      (killed_o),
        .jump_o        (jump_o),
        .jump_target_o (jump_target_o)
    );

    lsu_request u_lsu (
        .ctrl               (ctrl_bus.consumer),
        .killed_i           (killed_o),
        .addr_sum_i         (addr_sum),
        .rs2_i              (rs2_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    result_writeback u_writeback (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .op_i           (op_i),
        .killed_i       (killed_o),
        .ctrl           (ctrl_bus.consumer),
        .sum_i          (sum),
        .diff_i         (diff),
        .and_i          (and_res),
        .or_i           (or_res),
        .xor_i          (xor_res),
        .sll_i          (sll_res),
        .srl_i          (srl_res),
        .sra_i          (sra_res),
        .lt_i           (lt),
        .ltu_i          (ltu),
        .link_i         (link),
        .imm_i          (imm_i),
        .write_enable_o (write_enable_o),
        .op_o           (op_o),
        .result_o       (result_o)
    );

endmodule

//--- src/result_writeback.sv
/*
 * Write-back: result selection and the output register,
 * loaded on every cycle without stall
 */
`timescale 1ns/1ps

module result_writeback (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  ex_pkg::op_e             op_i,
    input  logic                    killed_i,
    ex_ctrl_if.consumer             ctrl,
    input  logic [ex_pkg::XLEN-1:0] sum_i,
    input  logic [ex_pkg::XLEN-1:0] diff_i,
    input  logic [ex_pkg::XLEN-1:0] and_i,
    input  logic [ex_pkg::XLEN-1:0] or_i,
    input  logic [ex_pkg::XLEN-1:0] xor_i,
    input  logic [ex_pkg::XLEN-1:0] sll_i,
    input  logic [ex_pkg::XLEN-1:0] srl_i,
    input  logic [ex_pkg::XLEN-1:0] sra_i,
    input  logic                    lt_i,
    input  logic                    ltu_i,
    input  logic [ex_pkg::XLEN-1:0] link_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    output logic                    write_enable_o,
    output ex_pkg::op_e             op_o,
    output logic [ex_pkg::XLEN-1:0] result_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] result;

    always_comb begin
        case (ctrl.alu_sel)
            ALU_DIFF: result = diff_i;
            ALU_AND:  result = and_i;
            ALU_OR:   result = or_i;
            ALU_XOR:  result = xor_i;
            ALU_SLL:  result = sll_i;
            ALU_SRL:  result = srl_i;
            ALU_SRA:  result = sra_i;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_i};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, ltu_i};
            ALU_IMM:  result = imm_i;
            ALU_LINK: result = link_i;
            default:  result = sum_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
        end else if (!stall_i) begin
            write_enable_o <= ctrl.writes_rd && !killed_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            op_o     <= op_i;
            result_o <= result;
        end
    end

endmodule

//--- src/lsu_request.sv
/*
 * Memory request: aligned address, load enable, store byte
 * enables and lane-replicated write data
 */
`timescale 1ns/1ps

module lsu_request (
    ex_ctrl_if.consumer             ctrl,
    input  logic                    killed_i,
    input  logic [ex_pkg::XLEN-1:0] addr_sum_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    output logic [ex_pkg::XLEN-1:0] mem_address_o,
    output logic                    mem_read_enable_o,
    output logic [3:0]              mem_write_enable_o,
    output logic [ex_pkg::XLEN-1:0] mem_write_data_o
);
    import ex_pkg::*;

    // Word-aligned, the lane goes into the byte enables
    assign mem_address_o     = {addr_sum_i[XLEN-1:2], 2'b00};
    assign mem_read_enable_o = ctrl.is_load && !killed_i;

    always_comb begin
        mem_write_enable_o = 4'b0000;
        if (!killed_i) begin
            case (ctrl.store_size)
                MEM_BYTE: mem_write_enable_o = 4'b0001 << addr_sum_i[1:0];
                MEM_HALF: mem_write_enable_o = addr_sum_i[1] ? 4'b1100 : 4'b0011;
                MEM_WORD: mem_write_enable_o = 4'b1111;
                default:  mem_write_enable_o = 4'b0000;
            endcase
        end
    end

    // Same data on every lane so the enables pick the right one
    always_comb begin
        case (ctrl.store_size)
            MEM_BYTE: mem_write_data_o = {4{rs2_i[7:0]}};
            MEM_HALF: mem_write_data_o = {2{rs2_i[15:0]}};
            default:  mem_write_data_o = rs2_i;
        endcase
    end

    always_comb begin
        assert final ($isunknown({mem_read_enable_o, mem_write_enable_o})
                      || !(mem_read_enable_o && |mem_write_enable_o))
            else $error("lsu_request: read and write requested together");
    end

endmodule

//--- src/branch_unit.sv
/*
 * Branch unit with condition evaluation, jump target, the current
 * tag and the kill of operations from a stale flow
 */
`timescale 1ns/1ps

module branch_unit #(
    parameter int TagWidth = ex_pkg::DEFAULT_TAG_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [TagWidth-1:0]     tag_i,
    ex_ctrl_if.consumer             ctrl,
    input  logic                    eq_i,
    input  logic                    lt_i,
    input  logic                    ltu_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  logic [ex_pkg::XLEN-1:0] addr_sum_i,
    output logic                    killed_o,
    output logic                    jump_o,
    output logic [ex_pkg::XLEN-1:0] jump_target_o
);
    import ex_pkg::*;

    logic [TagWidth-1:0] curr_tag;
    logic                cond_met;

    // Anything not from the current flow is dropped
    assign killed_o = curr_tag != tag_i;

    always_comb begin
        case (ctrl.br_cond)
            BR_ALWAYS: cond_met = 1'b1;
            BR_EQ:     cond_met = eq_i;
            BR_NE:     cond_met = !eq_i;
            BR_LT:     cond_met = lt_i;
            BR_LTU:    cond_met = ltu_i;
            BR_GE:     cond_met = !lt_i;
            BR_GEU:    cond_met = !ltu_i;
            default:   cond_met = 1'b0;
        endcase
    end

    assign jump_o = cond_met && !killed_o;

    // JALR target has bit 0 cleared
    assign jump_target_o = (ctrl.tgt_sel == TGT_REG_IMM)
                         ? {addr_sum_i[XLEN-1:1], 1'b0}
                         : pc_i + imm_i;

    ////////////////////////////////////////////////////////////////////
    // Current tag that advances on every taken jump even under stall
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump_o) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) killed_o |-> !jump_o)
        else $error("branch_unit: jump raised for a killed operation");

endmodule

//--- src/alu_execute.sv
/*
 * ALU with every candidate result and the comparison flags
 * computed in parallel from the operands
 */
`timescale 1ns/1ps

module alu_execute (
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] rs1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    output logic [ex_pkg::XLEN-1:0] sum_o,
    output logic [ex_pkg::XLEN-1:0] diff_o,
    output logic [ex_pkg::XLEN-1:0] and_o,
    output logic [ex_pkg::XLEN-1:0] or_o,
    output logic [ex_pkg::XLEN-1:0] xor_o,
    output logic [ex_pkg::XLEN-1:0] sll_o,
    output logic [ex_pkg::XLEN-1:0] srl_o,
    output logic [ex_pkg::XLEN-1:0] sra_o,
    output logic                    lt_o,
    output logic                    ltu_o,
    output logic                    eq_o,
    output logic [ex_pkg::XLEN-1:0] link_o,
    output logic [ex_pkg::XLEN-1:0] addr_sum_o
);
    import ex_pkg::*;

    logic [$clog2(XLEN)-1:0] shamt;

    // Shift amount from the low bits of rs2
    assign shamt = rs2_i[$clog2(XLEN)-1:0];

    assign sum_o  = rs1_i + rs2_i;
    assign diff_o = rs1_i - rs2_i;
    assign and_o  = rs1_i & rs2_i;
    assign or_o   = rs1_i | rs2_i;
    assign xor_o  = rs1_i ^ rs2_i;
    assign sll_o  = rs1_i << shamt;
    assign srl_o  = rs1_i >> shamt;
    assign sra_o  = $signed(rs1_i) >>> shamt;

    assign lt_o  = $signed(rs1_i) < $signed(rs2_i);
    assign ltu_o = rs1_i < rs2_i;
    assign eq_o  = rs1_i == rs2_i;

    // Return address of JAL and JALR
    assign link_o     = pc_i + XLEN'(4);
    // Shared by the memory address and the JALR target
    assign addr_sum_o = rs1_i + imm_i;

    // Flags must agree with the sign of the difference
    always_comb begin
        assert final ($isunknown({rs1_i, rs2_i})
                      || (eq_o == (diff_o == '0)
                          && lt_o == ((rs1_i[XLEN-1] != rs2_i[XLEN-1])
                                      ? rs1_i[XLEN-1] : diff_o[XLEN-1])
                          && ltu_o == ((rs1_i[XLEN-1] != rs2_i[XLEN-1])
                                       ? rs2_i[XLEN-1] : diff_o[XLEN-1])))
            else $error("alu_execute: comparison flags disagree with diff_o");
    end

endmodule

//--- src/op_decode.sv
/*
 * Operation classifier: maps each operation onto the control
 * fields used by the execute units
 */
`timescale 1ns/1ps

module op_decode (
    input  ex_pkg::op_e        op_i,
    ex_ctrl_if.decoder         ctrl
);
    import ex_pkg::*;

    always_comb begin
        // Plain register-writing ALU operation unless told otherwise
        ctrl.alu_sel    = ALU_SUM;
        ctrl.br_cond    = BR_NEVER;
        ctrl.tgt_sel    = TGT_PC_IMM;
        ctrl.is_load    = 1'b0;
        ctrl.store_size = MEM_NONE;
        ctrl.writes_rd  = 1'b1;

        case (op_i)
            NOP:  ctrl.writes_rd = 1'b0;
            ADD:  ctrl.alu_sel = ALU_SUM;
            SUB:  ctrl.alu_sel = ALU_DIFF;
            AND:  ctrl.alu_sel = ALU_AND;
            OR:   ctrl.alu_sel = ALU_OR;
            XOR:  ctrl.alu_sel = ALU_XOR;
            SLL:  ctrl.alu_sel = ALU_SLL;
            SRL:  ctrl.alu_sel = ALU_SRL;
            SRA:  ctrl.alu_sel = ALU_SRA;
            SLT:  ctrl.alu_sel = ALU_SLT;
            SLTU: ctrl.alu_sel = ALU_SLTU;
            LUI:  ctrl.alu_sel = ALU_IMM;

            // Jumps write the return address
            JAL: begin
                ctrl.alu_sel = ALU_LINK;
                ctrl.br_cond = BR_ALWAYS;
            end
            JALR: begin
                ctrl.alu_sel = ALU_LINK;
                ctrl.br_cond = BR_ALWAYS;
                ctrl.tgt_sel = TGT_REG_IMM;
            end

            // Conditional branches, no register write
            BEQ, BNE, BLT, BLTU, BGE, BGEU: begin
                ctrl.writes_rd = 1'b0;
                case (op_i)
                    BEQ:     ctrl.br_cond = BR_EQ;
                    BNE:     ctrl.br_cond = BR_NE;
                    BLT:     ctrl.br_cond = BR_LT;
                    BLTU:    ctrl.br_cond = BR_LTU;
                    BGE:     ctrl.br_cond = BR_GE;
                    default: ctrl.br_cond = BR_GEU;
                endcase
            end

            LB, LBU, LH, LHU, LW: ctrl.is_load = 1'b1;

            SB: begin
                ctrl.store_size = MEM_BYTE;
                ctrl.writes_rd  = 1'b0;
            end
            SH: begin
                ctrl.store_size = MEM_HALF;
                ctrl.writes_rd  = 1'b0;
            end
            SW: begin
                ctrl.store_size = MEM_WORD;
                ctrl.writes_rd  = 1'b0;
            end

            default: ctrl.writes_rd = 1'b0;
        endcase
    end

endmodule

//--- src/ex_ctrl_if.sv
/*
 * Decoded control of one operation, driven by the decoder and
 * read by the ALU, branch, memory and write-back units
 */
`timescale 1ns/1ps

interface ex_ctrl_if;
    import ex_pkg::*;

    alu_sel_e  alu_sel;
    br_cond_e  br_cond;
    tgt_sel_e  tgt_sel;
    logic      is_load;
    mem_size_e store_size;
    logic      writes_rd;

    modport decoder (
        output alu_sel,
        output br_cond,
        output tgt_sel,
        output is_load,
        output store_size,
        output writes_rd
    );

    modport consumer (
        input alu_sel,
        input br_cond,
        input tgt_sel,
        input is_load,
        input store_size,
        input writes_rd
    );

endinterface

//--- src/ex_pkg.sv
/*
 * Shared definitions of the execute stage: data and tag widths,
 * the operation enum and the enums of the decoded control fields
 */
package ex_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Tag width used when the top level is not overridden
    localparam int DEFAULT_TAG_W = 3;

    ////////////////////////////////////////////////////////////////////
    // Operations accepted by the stage
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP, ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    } op_e;

    ////////////////////////////////////////////////////////////////////
    // Decoded control
    ////////////////////////////////////////////////////////////////////

    // Result picked by write-back
    typedef enum logic [3:0] {
        ALU_SUM, ALU_DIFF, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_IMM, ALU_LINK
    } alu_sel_e;

    // Condition under which the operation redirects the flow
    typedef enum logic [2:0] {
        BR_NEVER, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_LTU, BR_GE, BR_GEU
    } br_cond_e;

    // PC relative for JAL and branches, register based for JALR
    typedef enum logic {
        TGT_PC_IMM,
        TGT_REG_IMM
    } tgt_sel_e;

    // Store width, NONE for every non-store
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

endpackage
